//--- Makefile
TOP := l2_cache_tb

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"

test:
	verilator --binary --timing --assert -f l2_cache.f --top-module $(TOP) -Mdir obj_dir
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "Test completed successfully"

clean:
	rm -rf obj_dir

//--- l2_cache.f
+incdir+rtl
rtl/l2_cache_pkg.sv
rtl/l2_ctl_if.sv
rtl/l2_cache_control.sv
rtl/l2_cache_datapath.sv
rtl/l2_cache.sv
tests/l2_cache_clkgen.sv
tests/l2_cache_checker.sv
tests/l2_cache_tb.sv

//--- rtl/l2_cache.sv
`timescale 1ns/1ps
`default_nettype none

`include "l2_cache_macros.svh"

module l2_cache (
    input  logic clk,
    input  logic reset,
    input  logic mem_read,
    input  logic mem_write,
    input  logic [`L2_ADDR_BITS-1:0] mem_address,
    input  l2_cache_pkg::l2_line_t mem_wdata,
    output l2_cache_pkg::l2_line_t mem_rdata,
    output logic mem_resp,
    output logic pmem_read,
    output logic pmem_write,
    output logic [`L2_ADDR_BITS-1:0] pmem_address,
    output l2_cache_pkg::l2_line_t pmem_wdata,
    input  l2_cache_pkg::l2_line_t pmem_rdata,
    input  logic pmem_resp
);

    l2_ctl_if bus ();

    l2_cache_control i_control (
        .clk        (clk),
        .reset      (reset),
        .mem_read   (mem_read),
        .mem_write  (mem_write),
        .pmem_resp  (pmem_resp),
        .mem_resp   (mem_resp),
        .pmem_read  (pmem_read),
        .pmem_write (pmem_write),
        .bus        (bus.control)
    );

    l2_cache_datapath i_datapath (
        .clk          (clk),
        .reset        (reset),
        .mem_address  (mem_address),
        .mem_wdata    (mem_wdata),
        .mem_rdata    (mem_rdata),
        .pmem_rdata   (pmem_rdata),
        .pmem_address (pmem_address),
        .pmem_wdata   (pmem_wdata),
        .bus          (bus.datapath)
    );

endmodule

`default_nettype wire

//--- rtl/l2_cache_control.sv
`timescale 1ns/1ps
`default_nettype none

`include "l2_cache_macros.svh"

module l2_cache_control (
    input  logic clk,
    input  logic reset,
    input  logic mem_read,
    input  logic mem_write,
    input  logic pmem_resp,
    output logic mem_resp,
    output logic pmem_read,
    output logic pmem_write,
    l2_ctl_if.control bus
);
    import l2_cache_pkg::*;

    l2_state_e state;
    l2_state_e next_state;

    logic req;
    logic hit;
    l2_way_idx_t hit_way;
    logic half_ptr;
    logic leaf_ptr;
    logic [1:0] pair;
    l2_way_idx_t victim;
    logic victim_dirty;

    assign req = mem_read ^ mem_write; // the L1 holds exactly one of them

    always_comb begin
        hit = 1'b0;
        hit_way = '0;
        for (int w = 0; w < `L2_WAYS; w++) begin
            if (bus.way_state[w].hit) begin
                hit = 1'b1;
                hit_way = l2_way_idx_t'(w);
            end
        end
    end

    // follow the pointers down from the root, 1 means the upper half
    always_comb begin
        half_ptr = bus.lru[0] ? bus.lru[2] : bus.lru[1];
        pair = {bus.lru[0], half_ptr};
        leaf_ptr = bus.lru[{1'b0, pair} + 3'd3];
        victim = {bus.lru[0], half_ptr, leaf_ptr};
    end

    assign victim_dirty = bus.way_state[victim].valid & bus.way_state[victim].dirty;
    assign bus.victim = victim;

    // every node on the accessed way's path turns to point away from it
    always_comb begin
        bus.lru_next = bus.lru;
        bus.lru_next[0] = ~hit_way[2];
        bus.lru_next[{2'b00, hit_way[2]} + 3'd1] = ~hit_way[1];
        bus.lru_next[{1'b0, hit_way[2:1]} + 3'd3] = ~hit_way[0];
    end

    always_comb begin
        bus.ctl = '0;
        mem_resp = 1'b0;
        pmem_read = 1'b0;
        pmem_write = 1'b0;
        next_state = state;

        case (state)
            process_request: begin
                if (req) begin
                    if (hit) begin
                        mem_resp = 1'b1; // same cycle, the arrays read asynchronously
                        bus.ctl.load_lru = 1'b1;
                        if (mem_write) begin
                            bus.ctl.way[hit_way].d_in = 1'b1;
                            bus.ctl.way[hit_way].load_d = 1'b1;
                            bus.ctl.way[hit_way].load_td = 1'b1;
                        end
                    end else if (victim_dirty) begin
                        next_state = write_back;
                    end else begin
                        next_state = fetch_cline;
                    end
                end
            end
            write_back: begin
                pmem_write = 1'b1;
                bus.ctl.wb_sel = 1'b1;
                if (pmem_resp) begin
                    next_state = fetch_cline;
                end
            end
            fetch_cline: begin
                pmem_read = 1'b1;
                if (pmem_resp) begin
                    bus.ctl.way[victim].v_in = 1'b1;
                    bus.ctl.way[victim].d_in = 1'b0;
                    bus.ctl.way[victim].load_v = 1'b1;
                    bus.ctl.way[victim].load_d = 1'b1;
                    bus.ctl.way[victim].load_td = 1'b1;
                    next_state = process_request; // the retry hits next cycle
                end
            end
            default: begin
                next_state = process_request;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= process_request;
        end else begin
            state <= next_state;
        end
    end

endmodule

`default_nettype wire

//--- rtl/l2_cache_datapath.sv
`timescale 1ns/1ps
`default_nettype none

`include "l2_cache_macros.svh"

module l2_cache_datapath (
    input  logic clk,
    input  logic reset,
    input  logic [`L2_ADDR_BITS-1:0] mem_address,
    input  l2_cache_pkg::l2_line_t mem_wdata,
    output l2_cache_pkg::l2_line_t mem_rdata,
    input  l2_cache_pkg::l2_line_t pmem_rdata,
    output logic [`L2_ADDR_BITS-1:0] pmem_address,
    output l2_cache_pkg::l2_line_t pmem_wdata,
    l2_ctl_if.datapath bus
);
    import l2_cache_pkg::*;

    localparam int SETS = 1 << `L2_INDEX_BITS;

    l2_tag_t tag_arr [`L2_WAYS][SETS];
    l2_line_t data_arr [`L2_WAYS][SETS];
    logic valid_arr [`L2_WAYS][SETS];
    logic dirty_arr [`L2_WAYS][SETS];
    l2_lru_t lru_arr [SETS];

    logic [`L2_INDEX_BITS-1:0] index;
    l2_tag_t cpu_tag;
    l2_tag_t victim_tag;
    logic fill_any;
    l2_line_t line_in;

    assign index = mem_address[`L2_OFFSET_BITS +: `L2_INDEX_BITS];
    assign cpu_tag = mem_address[`L2_ADDR_BITS-1 -: `L2_TAG_BITS];

    always_comb begin
        for (int w = 0; w < `L2_WAYS; w++) begin
            bus.way_state[w].valid = valid_arr[w][index];
            bus.way_state[w].dirty = dirty_arr[w][index];
            bus.way_state[w].hit = valid_arr[w][index] && (tag_arr[w][index] == cpu_tag);
        end
    end

    assign bus.lru = lru_arr[index];

    // at most one way hits, so or-ing the gated lines is a mux
    always_comb begin
        mem_rdata = '0;
        for (int w = 0; w < `L2_WAYS; w++) begin
            if (bus.way_state[w].hit) begin
                mem_rdata = mem_rdata | data_arr[w][index];
            end
        end
    end

    always_comb begin
        fill_any = 1'b0;
        for (int w = 0; w < `L2_WAYS; w++) begin
            fill_any = fill_any | bus.ctl.way[w].load_v;
        end
    end

    assign line_in = fill_any ? pmem_rdata : mem_wdata; // memory line on a fill, CPU line on a write

    assign victim_tag = tag_arr[bus.victim][index];
    assign pmem_wdata = data_arr[bus.victim][index];

    always_comb begin
        if (bus.ctl.wb_sel && !fill_any) begin
            pmem_address = {victim_tag, index, {`L2_OFFSET_BITS{1'b0}}};
        end else begin
            pmem_address = {cpu_tag, index, {`L2_OFFSET_BITS{1'b0}}};
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int s = 0; s < SETS; s++) begin
                lru_arr[s] <= '0;
                for (int w = 0; w < `L2_WAYS; w++) begin
                    valid_arr[w][s] <= 1'b0;
                    dirty_arr[w][s] <= 1'b0;
                end
            end
        end else begin
            if (bus.ctl.load_lru) begin
                lru_arr[index] <= bus.lru_next;
            end
            for (int w = 0; w < `L2_WAYS; w++) begin
                if (bus.ctl.way[w].load_v) begin
                    valid_arr[w][index] <= bus.ctl.way[w].v_in;
                end
                if (bus.ctl.way[w].load_d) begin
                    dirty_arr[w][index] <= bus.ctl.way[w].d_in;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        for (int w = 0; w < `L2_WAYS; w++) begin
            if (bus.ctl.way[w].load_td) begin
                tag_arr[w][index] <= cpu_tag; // unchanged on a write hit
                data_arr[w][index] <= line_in;
            end
        end
    end

endmodule

`default_nettype wire

//--- rtl/l2_cache_macros.svh
`ifndef L2_CACHE_MACROS_SVH
`define L2_CACHE_MACROS_SVH

// address split is tag | index | offset, 9 + 3 + 4 bits
`define L2_ADDR_BITS   16
`define L2_OFFSET_BITS 4
`define L2_INDEX_BITS  3
`define L2_TAG_BITS    9

`define L2_LINE_BITS   128
`define L2_WAYS        8

`endif

//--- rtl/l2_cache_pkg.sv
`default_nettype none

`include "l2_cache_macros.svh"

package l2_cache_pkg;

    typedef enum logic [1:0] {
        process_request,
        fetch_cline,
        write_back
    } l2_state_e;

    typedef logic [`L2_LINE_BITS-1:0] l2_line_t;
    typedef logic [`L2_TAG_BITS-1:0] l2_tag_t;
    typedef logic [$clog2(`L2_WAYS)-1:0] l2_way_idx_t;

    // bit 0 is the root, bits 1 and 2 the halves, bits 3 to 6 the leaf pairs
    typedef logic [`L2_WAYS-2:0] l2_lru_t;

    typedef struct packed {
        logic hit;
        logic valid;
        logic dirty;
    } l2_way_status_t;

    typedef l2_way_status_t [`L2_WAYS-1:0] l2_way_state_t;

    typedef struct packed {
        logic v_in;
        logic d_in;
        logic load_v;
        logic load_d;
        logic load_td; // loads tag and line together
    } l2_way_ctl_t;

    typedef struct packed {
        l2_way_ctl_t [`L2_WAYS-1:0] way;
        logic load_lru;
        logic wb_sel; // high while the victim line goes out to memory
    } l2_ctl_t;

endpackage

`default_nettype wire

//--- rtl/l2_ctl_if.sv
`timescale 1ns/1ps
`default_nettype none

interface l2_ctl_if;
    import l2_cache_pkg::*;

    l2_way_state_t way_state; // per-way hit, valid and dirty of the addressed set
    l2_lru_t lru;             // tree bits of the addressed set
    l2_ctl_t ctl;
    l2_lru_t lru_next;
    l2_way_idx_t victim;

    modport control (
        input  way_state,
        input  lru,
        output ctl,
        output lru_next,
        output victim
    );

    modport datapath (
        input  ctl,
        input  lru_next,
        input  victim,
        output way_state,
        output lru
    );

endinterface

`default_nettype wire

//--- tests/l2_cache_checker.sv
`timescale 1ns/1ps
`default_nettype none

module l2_cache_checker (
    input wire logic clk,
    input wire logic reset,
    input wire logic mem_read,
    input wire logic mem_write,
    input wire logic mem_resp,
    input wire logic pmem_read,
    input wire logic pmem_write,
    input wire logic [15:0] pmem_address,
    input wire logic pmem_resp
);

    a_pmem_exclusive: assert property (@(posedge clk) disable iff (reset)
        !(pmem_read && pmem_write))
        else $error("pmem_read and pmem_write high together");

    a_resp_needs_request: assert property (@(posedge clk) disable iff (reset)
        mem_resp |-> (mem_read || mem_write))
        else $error("mem_resp without a held request");

    // the address may only move once memory has answered
    a_pmem_addr_stable: assert property (@(posedge clk) disable iff (reset)
        (pmem_read || pmem_write) && !pmem_resp |=> $stable(pmem_address))
        else $error("pmem_address changed while a memory request was held");

    a_idle_after_reset: assert property (@(posedge clk)
        reset |=> !pmem_read && !pmem_write && !mem_resp)
        else $error("control outputs active in the cycle after reset");

endmodule

bind l2_cache l2_cache_checker i_checker (
    .clk          (clk),
    .reset        (reset),
    .mem_read     (mem_read),
    .mem_write    (mem_write),
    .mem_resp     (mem_resp),
    .pmem_read    (pmem_read),
    .pmem_write   (pmem_write),
    .pmem_address (pmem_address),
    .pmem_resp    (pmem_resp)
);

`default_nettype wire

//--- tests/l2_cache_clkgen.sv
`timescale 1ns/1ps
`default_nettype none

module l2_cache_clkgen (
    output logic clk,
    output logic reset
);

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk; // 40 ns period
    end

    initial begin
        reset <= 1'b1;
        repeat (3) @(posedge clk);
        reset <= 1'b0;
    end

endmodule

`default_nettype wire

//--- tests/l2_cache_stim.txt
# op(R/W) address write_line expected_read_line expected_miss writeback_address
# writeback_address ffff means no write-back is expected, write lines are not read back
R 0080 0 00800080008000800080008000800080 1 ffff
R 0080 0 00800080008000800080008000800080 0 ffff
W 0080 0123456789abcdeffedcba9876543210 0 0 ffff
R 0080 0 0123456789abcdeffedcba9876543210 0 ffff
R 0100 0 01000100010001000100010001000100 1 ffff
R 0180 0 01800180018001800180018001800180 1 ffff
R 0200 0 02000200020002000200020002000200 1 ffff
R 0280 0 02800280028002800280028002800280 1 ffff
R 0300 0 03000300030003000300030003000300 1 ffff
R 0380 0 03800380038003800380038003800380 1 ffff
R 0400 0 04000400040004000400040004000400 1 ffff
R 0480 0 04800480048004800480048004800480 1 0080
R 0080 0 0123456789abcdeffedcba9876543210 1 ffff
R 0100 0 01000100010001000100010001000100 1 ffff
W 0180 a5a5a5a55a5a5a5a0f0f0f0ff0f0f0f0 0 1 ffff
R 0180 0 a5a5a5a55a5a5a5a0f0f0f0ff0f0f0f0 0 ffff
R 0010 0 00100010001000100010001000100010 1 ffff
R 0010 0 00100010001000100010001000100010 0 ffff

//--- tests/l2_cache_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "l2_cache_macros.svh"

module l2_cache_tb;
    import l2_cache_pkg::*;

    logic clk;
    logic reset;
    logic mem_read = 1'b0;
    logic mem_write = 1'b0;
    logic [`L2_ADDR_BITS-1:0] mem_address = '0;
    l2_line_t mem_wdata = '0;
    l2_line_t mem_rdata;
    logic mem_resp;
    logic pmem_read;
    logic pmem_write;
    logic [`L2_ADDR_BITS-1:0] pmem_address;
    l2_line_t pmem_wdata;
    l2_line_t pmem_rdata = '0;
    logic pmem_resp = 1'b0;

    int errors = 0;
    int checks = 0;
    bit stim_ready = 0;
    int n_lines = 0;

    byte op_q[$];
    logic [15:0] addr_q[$];
    l2_line_t wdata_q[$];
    l2_line_t exp_q[$];
    logic miss_q[$];
    logic [15:0] wb_q[$];

    l2_line_t mem_lines [logic [15:0]];
    logic mem_busy = 1'b0;
    int mem_delay = 0;

    l2_cache_clkgen i_clkgen (.clk(clk), .reset(reset));

    l2_cache i_dut (.*);

    function automatic l2_line_t memory_line(input logic [15:0] addr);
        if (mem_lines.exists(addr)) begin
            return mem_lines[addr];
        end
        return {8{addr}}; // untouched lines hold their own address in every word
    endfunction

    // memory answers 1 to 4 cycles after it first sees a request
    initial begin
        void'($urandom(32'hee6a3de8));
        forever begin
            @(posedge clk);
            if (reset) begin
                pmem_resp <= 1'b0;
                mem_busy <= 1'b0;
            end else if (pmem_resp) begin
                if (pmem_write) begin
                    mem_lines[pmem_address] = pmem_wdata;
                end
                pmem_resp <= 1'b0;
                mem_busy <= 1'b0;
            end else if (pmem_read || pmem_write) begin
                if (!mem_busy) begin
                    mem_busy <= 1'b1;
                    mem_delay <= int'($urandom_range(0, 3));
                end else if (mem_delay == 0) begin
                    pmem_resp <= 1'b1;
                    pmem_rdata <= memory_line(pmem_address);
                end else begin
                    mem_delay <= mem_delay - 1;
                end
            end
        end
    end

    task automatic check_line(input string name, input l2_line_t got, input l2_line_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("CHECK FAILED t=%0t %s expected %h got %h", $time, name, exp, got);
        end
    endtask

    task automatic check_addr(input string name, input logic [15:0] got,
                              input logic [15:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("CHECK FAILED t=%0t %s expected %h got %h", $time, name, exp, got);
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("CHECK FAILED t=%0t %s expected %b got %b", $time, name, exp, got);
        end
    endtask

    task automatic load_stimulus();
        int fd;
        int count;
        string line;
        byte op;
        logic [15:0] addr;
        l2_line_t wdata;
        l2_line_t exp;
        logic miss;
        logic [15:0] wb;
        fd = $fopen("tests/l2_cache_stim.txt", "r");
        if (fd == 0) begin
            errors++;
            $display("could not open the stimulus file");
            return;
        end
        while (!$feof(fd)) begin
            count = $fgets(line, fd);
            if (count > 0 && line.len() > 0 && line[0] != "#") begin
                count = $sscanf(line, "%c %h %h %h %h %h", op, addr, wdata, exp, miss, wb);
                if (count == 6) begin
                    op_q.push_back(op);
                    addr_q.push_back(addr);
                    wdata_q.push_back(wdata);
                    exp_q.push_back(exp);
                    miss_q.push_back(miss);
                    wb_q.push_back(wb);
                end
            end
        end
        $fclose(fd);
        n_lines = op_q.size();
        if (n_lines == 0) begin
            errors++;
            $display("the stimulus file holds no usable lines");
        end
    endtask

    task automatic run_access(input int i);
        logic saw_read;
        logic saw_write;
        logic done;
        logic [15:0] wb_addr;
        saw_read = 1'b0;
        saw_write = 1'b0;
        done = 1'b0;
        wb_addr = '0;
        @(posedge clk);
        mem_read <= (op_q[i] == "R");
        mem_write <= (op_q[i] == "W");
        mem_address <= addr_q[i];
        mem_wdata <= wdata_q[i];
        while (!done) begin
            @(negedge clk);
            if (pmem_read) saw_read = 1'b1;
            if (pmem_write && !saw_write) begin
                saw_write = 1'b1;
                wb_addr = pmem_address;
            end
            done = mem_resp;
        end
        if (op_q[i] == "R") begin
            check_line("mem_rdata", mem_rdata, exp_q[i]);
        end
        check_bit("miss", saw_read, miss_q[i]);
        if (wb_q[i] == 16'hffff) begin
            if (saw_write) begin
                errors++;
                $display("line %0d wrote a line back to memory where none was due", i);
            end
        end else if (!saw_write) begin
            errors++;
            $display("line %0d did not write the victim line back to memory", i);
        end else begin
            check_addr("pmem_address", wb_addr, wb_q[i]);
        end
        @(posedge clk);
        mem_read <= 1'b0;
        mem_write <= 1'b0;
    endtask

    initial begin
        int limit;
        limit = 0;
        wait (stim_ready);
        limit = (n_lines + 5) * 20 * 40; // 20 cycles of 40 ns per line
        #(limit);
        $display("watchdog expired after %0d ns before all accesses finished", limit);
        $display("Test failed");
        $finish;
    end

    initial begin
        load_stimulus();
        stim_ready = 1;
        @(negedge reset);
        @(negedge clk);
        check_bit("mem_resp", mem_resp, 1'b0);
        check_bit("pmem_read", pmem_read, 1'b0);
        check_bit("pmem_write", pmem_write, 1'b0);
        for (int i = 0; i < n_lines; i++) begin
            run_access(i);
        end
        $display("checks %0d errors %0d", checks, errors);
        if (errors == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire
